/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // 3r-type opcodes, matched against inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_nor   = 17'h00028;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2ri12-type opcodes, matched against inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    localparam logic [6:0] op_lu12i_w = 7'h0a;  // inst[31:25]

    // branch opcodes, matched against inst[31:26]
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_lui,
        alu_none
    } alu_op_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
        logic [xlen-1:0] imm;
        alu_op_t         alu_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            mem_read;
        logic            mem_write;
        logic [4:0]      dest;
        logic            gr_we;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] result;
        logic            mem_read;
        logic            mem_write;
        logic [4:0]      dest;
        logic            gr_we;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] result;
        logic [4:0]      dest;
        logic            gr_we;
    } mem_wb_t;

    // dest is zero when nothing is written, so it never matches a source
    typedef struct packed {
        logic [4:0]      dest;
        logic [xlen-1:0] value;
        logic            is_load;
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

`default_nettype wire

/* rf_read_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rf_read_if;
    logic [4:0]               raddr1;
    logic [4:0]               raddr2;
    logic [cpu_pkg::xlen-1:0] rdata1;
    logic [cpu_pkg::xlen-1:0] rdata2;

    modport master (
        output raddr1, raddr2,
        input  rdata1, rdata2
    );

    modport slave (
        input  raddr1, raddr2,
        output rdata1, rdata2
    );
endinterface

`default_nettype wire

/* if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  cpu_pkg::br_t        br,
    input  wire                       id_allow_in,
    output logic [cpu_pkg::xlen-1:0]  inst_addr,
    input  wire  [31:0]               inst_rdata,
    output logic                      if_to_id_valid,
    output cpu_pkg::if_id_t           if_to_id_data
);

    logic                     if_valid;
    logic [cpu_pkg::xlen-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            if_valid <= 1'b0;
            pc       <= cpu_pkg::reset_pc;
        end else begin
            if_valid <= 1'b1;  // fetch starts at reset_pc one cycle after release
            if (br.taken) begin
                pc <= br.target;
            end else if (if_to_id_valid && id_allow_in) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign inst_addr = pc;  // held while decode stalls, so the instruction is held too

    // the instruction fetched behind a taken branch is dropped
    assign if_to_id_valid = if_valid && !br.taken;
    assign if_to_id_data  = '{pc: pc, inst: inst_rdata};

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   if_to_id_valid,
    output logic                  id_allow_in,
    input  wire cpu_pkg::if_id_t  if_to_id_data,
    output logic                  id_to_ex_valid,
    input  wire                   ex_allow_in,
    output cpu_pkg::id_ex_t       id_to_ex_data,
    output cpu_pkg::br_t          br,
    rf_read_if.master             rf,
    input  wire cpu_pkg::fwd_t    ex_fwd,
    input  wire cpu_pkg::fwd_t    mem_fwd,
    input  wire cpu_pkg::fwd_t    wb_fwd
);

    logic                     id_valid;
    cpu_pkg::if_id_t          data_r;
    logic [31:0]              inst;
    logic [cpu_pkg::xlen-1:0] pc;
    logic [4:0]               rd, rj, rk;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_nor, inst_xor;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_beq, inst_bne, inst_b, inst_bl, inst_jirl;

    logic                     src2_is_4, need_si12, need_si26;
    logic                     no_rj, no_rkd, gr_we;
    logic [4:0]               dest;
    logic [cpu_pkg::xlen-1:0] imm, br_offs, rj_value, rkd_value;
    cpu_pkg::alu_op_t         alu_op;
    logic                     need_wait, br_taken;
    logic [cpu_pkg::xlen-1:0] br_target;

    // the youngest stage that writes addr wins over the register file
    function automatic logic [cpu_pkg::xlen-1:0] fwd_pick(
        input logic [4:0]               addr,
        input logic [cpu_pkg::xlen-1:0] rdata,
        input cpu_pkg::fwd_t            ex,
        input cpu_pkg::fwd_t            mem,
        input cpu_pkg::fwd_t            wb
    );
        if (addr == 5'd0) return rdata;
        if (addr == ex.dest) return ex.value;
        if (addr == mem.dest) return mem.value;
        if (addr == wb.dest) return wb.value;
        return rdata;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allow_in) begin
            id_valid <= if_to_id_valid;
        end
        if (if_to_id_valid && id_allow_in) begin
            data_r <= if_to_id_data;
        end
    end

    assign pc   = data_r.pc;
    assign inst = data_r.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign inst_add_w   = inst[31:15] == cpu_pkg::op_add_w;
    assign inst_sub_w   = inst[31:15] == cpu_pkg::op_sub_w;
    assign inst_slt     = inst[31:15] == cpu_pkg::op_slt;
    assign inst_sltu    = inst[31:15] == cpu_pkg::op_sltu;
    assign inst_and     = inst[31:15] == cpu_pkg::op_and;
    assign inst_or      = inst[31:15] == cpu_pkg::op_or;
    assign inst_nor     = inst[31:15] == cpu_pkg::op_nor;
    assign inst_xor     = inst[31:15] == cpu_pkg::op_xor;
    assign inst_addi_w  = inst[31:22] == cpu_pkg::op_addi_w;
    assign inst_ld_w    = inst[31:22] == cpu_pkg::op_ld_w;
    assign inst_st_w    = inst[31:22] == cpu_pkg::op_st_w;
    assign inst_lu12i_w = inst[31:25] == cpu_pkg::op_lu12i_w;
    assign inst_jirl    = inst[31:26] == cpu_pkg::op_jirl;
    assign inst_b       = inst[31:26] == cpu_pkg::op_b;
    assign inst_bl      = inst[31:26] == cpu_pkg::op_bl;
    assign inst_beq     = inst[31:26] == cpu_pkg::op_beq;
    assign inst_bne     = inst[31:26] == cpu_pkg::op_bne;

    always_comb begin
        if (inst_add_w || inst_addi_w || inst_ld_w || inst_st_w || inst_bl || inst_jirl) begin
            alu_op = cpu_pkg::alu_add;  // links compute pc + 4 through the adder
        end else if (inst_sub_w) begin
            alu_op = cpu_pkg::alu_sub;
        end else if (inst_slt) begin
            alu_op = cpu_pkg::alu_slt;
        end else if (inst_sltu) begin
            alu_op = cpu_pkg::alu_sltu;
        end else if (inst_and) begin
            alu_op = cpu_pkg::alu_and;
        end else if (inst_or) begin
            alu_op = cpu_pkg::alu_or;
        end else if (inst_nor) begin
            alu_op = cpu_pkg::alu_nor;
        end else if (inst_xor) begin
            alu_op = cpu_pkg::alu_xor;
        end else if (inst_lu12i_w) begin
            alu_op = cpu_pkg::alu_lui;
        end else begin
            alu_op = cpu_pkg::alu_none;
        end
    end

    assign src2_is_4 = inst_jirl || inst_bl;
    assign need_si12 = inst_addi_w || inst_ld_w || inst_st_w;
    assign need_si26 = inst_b || inst_bl;
    assign no_rj     = inst_lu12i_w || inst_b || inst_bl;
    assign no_rkd    = need_si12 && !inst_st_w || inst_lu12i_w || inst_jirl || need_si26;
    assign gr_we     = inst_add_w || inst_sub_w || inst_slt || inst_sltu || inst_and
                    || inst_or || inst_nor || inst_xor || inst_addi_w || inst_lu12i_w
                    || inst_ld_w || inst_bl || inst_jirl;
    assign dest      = (inst_bl ? 5'd1 : rd) & {5{gr_we}};

    assign imm = src2_is_4    ? 32'd4 :
                 inst_lu12i_w ? {inst[24:5], 12'b0} :
                 need_si12    ? {{20{inst[21]}}, inst[21:10]} :
                                {20'b0, inst[21:10]};

    assign br_offs = need_si26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                                 {{14{inst[25]}}, inst[25:10], 2'b0};

    assign rf.raddr1 = rj;
    assign rf.raddr2 = (inst_beq || inst_bne || inst_st_w) ? rd : rk;

    assign rj_value  = fwd_pick(rf.raddr1, rf.rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rkd_value = fwd_pick(rf.raddr2, rf.rdata2, ex_fwd, mem_fwd, wb_fwd);

    // a load in execute has no value yet, wait one cycle for the memory forward
    assign need_wait = ex_fwd.is_load && (
                           !no_rj && rf.raddr1 != 5'd0 && rf.raddr1 == ex_fwd.dest
                        || !no_rkd && rf.raddr2 != 5'd0 && rf.raddr2 == ex_fwd.dest);

    assign id_allow_in    = !id_valid || (!need_wait && ex_allow_in);
    assign id_to_ex_valid = id_valid && !need_wait;

    assign br_taken  = id_valid && !need_wait && (inst_beq && rj_value == rkd_value
                                               || inst_bne && rj_value != rkd_value
                                               || inst_b || inst_bl || inst_jirl);
    assign br_target = inst_jirl ? rj_value + {{14{inst[25]}}, inst[25:10], 2'b0} :
                                   pc + br_offs;
    assign br        = '{taken: br_taken, target: br_target};

    assign id_to_ex_data = '{pc, rj_value, rkd_value, imm, alu_op, inst_jirl || inst_bl,
                             need_si12 || inst_lu12i_w || src2_is_4,
                             inst_ld_w, inst_st_w, dest, gr_we};

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input wire                      clk,
    rf_read_if.slave                rf,
    input wire                      we,
    input wire [4:0]                waddr,
    input wire [cpu_pkg::xlen-1:0]  wdata
);

    logic [cpu_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write, decode forwards the new one
    assign rf.rdata1 = (rf.raddr1 == 5'd0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == 5'd0) ? '0 : regs[rf.raddr2];

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       id_to_ex_valid,
    output logic                      ex_allow_in,
    input  wire cpu_pkg::id_ex_t      id_to_ex_data,
    output logic                      ex_to_mem_valid,
    output cpu_pkg::ex_mem_t          ex_to_mem_data,
    output logic [cpu_pkg::xlen-1:0]  store_data,
    output cpu_pkg::fwd_t             ex_fwd
);

    logic                     ex_valid;
    cpu_pkg::id_ex_t          data_r;
    logic [cpu_pkg::xlen-1:0] src1, src2, result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (ex_allow_in) begin
            ex_valid <= id_to_ex_valid;
        end
        if (id_to_ex_valid && ex_allow_in) begin
            data_r <= id_to_ex_data;
        end
    end

    assign ex_allow_in = 1'b1;  // memory never waits, so execute never holds

    assign src1 = data_r.src1_is_pc ? data_r.pc : data_r.rj_value;
    assign src2 = data_r.src2_is_imm ? data_r.imm : data_r.rkd_value;

    always_comb begin
        case (data_r.alu_op)
            cpu_pkg::alu_add:  result = src1 + src2;
            cpu_pkg::alu_sub:  result = src1 - src2;
            cpu_pkg::alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            cpu_pkg::alu_sltu: result = {31'b0, src1 < src2};
            cpu_pkg::alu_and:  result = src1 & src2;
            cpu_pkg::alu_or:   result = src1 | src2;
            cpu_pkg::alu_nor:  result = ~(src1 | src2);
            cpu_pkg::alu_xor:  result = src1 ^ src2;
            cpu_pkg::alu_lui:  result = src2;  // imm is already shifted in decode
            default:           result = '0;
        endcase
    end

    assign ex_to_mem_valid = ex_valid;
    assign ex_to_mem_data  = '{data_r.pc, result, data_r.mem_read, data_r.mem_write,
                               data_r.dest, data_r.gr_we};
    assign store_data      = data_r.rkd_value;

    // for a load the value here is the address, decode stalls on is_load
    assign ex_fwd = '{dest: ex_valid ? data_r.dest : 5'd0,
                      value: result,
                      is_load: ex_valid && data_r.mem_read};

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       ex_to_mem_valid,
    input  wire cpu_pkg::ex_mem_t     ex_to_mem_data,
    input  wire [cpu_pkg::xlen-1:0]   store_data,
    output logic                      data_en,
    output logic                      data_we,
    output logic [cpu_pkg::xlen-1:0]  data_addr,
    output logic [cpu_pkg::xlen-1:0]  data_wdata,
    input  wire  [cpu_pkg::xlen-1:0]  data_rdata,
    output logic                      mem_to_wb_valid,
    output cpu_pkg::mem_wb_t          mem_to_wb_data,
    output cpu_pkg::fwd_t             mem_fwd
);

    logic                     mem_valid;
    cpu_pkg::ex_mem_t         data_r;
    logic [cpu_pkg::xlen-1:0] wdata_r;
    logic [cpu_pkg::xlen-1:0] final_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_to_mem_valid;
        end
        if (ex_to_mem_valid) begin
            data_r  <= ex_to_mem_data;
            wdata_r <= store_data;
        end
    end

    assign data_en    = mem_valid && (data_r.mem_read || data_r.mem_write);
    assign data_we    = mem_valid && data_r.mem_write;
    assign data_addr  = data_r.result;
    assign data_wdata = wdata_r;

    assign final_result = data_r.mem_read ? data_rdata : data_r.result;

    assign mem_to_wb_valid = mem_valid;
    assign mem_to_wb_data  = '{data_r.pc, final_result, data_r.dest, data_r.gr_we};
    assign mem_fwd = '{dest: mem_valid ? data_r.dest : 5'd0, value: final_result, is_load: 1'b0};

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       mem_to_wb_valid,
    input  wire cpu_pkg::mem_wb_t     mem_to_wb_data,
    output logic                      rf_we,
    output logic [4:0]                rf_waddr,
    output logic [cpu_pkg::xlen-1:0]  rf_wdata,
    output cpu_pkg::fwd_t             wb_fwd,
    output logic [cpu_pkg::xlen-1:0]  debug_wb_pc,
    output logic                      debug_wb_we,
    output logic [4:0]                debug_wb_rnum,
    output logic [cpu_pkg::xlen-1:0]  debug_wb_data
);

    logic             wb_valid;
    cpu_pkg::mem_wb_t data_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_to_wb_valid;
        end
        if (mem_to_wb_valid) begin
            data_r <= mem_to_wb_data;
        end
    end

    assign rf_we    = wb_valid && data_r.gr_we;
    assign rf_waddr = data_r.dest;
    assign rf_wdata = data_r.result;

    assign wb_fwd = '{dest: wb_valid ? data_r.dest : 5'd0, value: data_r.result, is_load: 1'b0};

    assign debug_wb_pc   = data_r.pc;
    assign debug_wb_we   = rf_we && data_r.dest != 5'd0;  // writes to r0 leave no trace
    assign debug_wb_rnum = data_r.dest;
    assign debug_wb_data = data_r.result;

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire         clk,
    input  wire         reset,
    output logic [31:0] inst_addr,
    input  wire  [31:0] inst_rdata,
    output logic        data_en,
    output logic        data_we,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    input  wire  [31:0] data_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_we,
    output logic [4:0]  debug_wb_rnum,
    output logic [31:0] debug_wb_data
);

    cpu_pkg::br_t     br;
    cpu_pkg::if_id_t  if_to_id_data;
    cpu_pkg::id_ex_t  id_to_ex_data;
    cpu_pkg::ex_mem_t ex_to_mem_data;
    cpu_pkg::mem_wb_t mem_to_wb_data;
    cpu_pkg::fwd_t    ex_fwd, mem_fwd, wb_fwd;
    logic             if_to_id_valid, id_allow_in;
    logic             id_to_ex_valid, ex_allow_in;
    logic             ex_to_mem_valid, mem_to_wb_valid;
    logic [31:0]      store_data;
    logic             rf_we;
    logic [4:0]       rf_waddr;
    logic [31:0]      rf_wdata;

    rf_read_if rf_bus ();

    if_stage if_i (
        .clk, .reset, .br, .id_allow_in, .inst_addr, .inst_rdata,
        .if_to_id_valid, .if_to_id_data
    );

    id_stage id_i (
        .clk, .reset, .if_to_id_valid, .id_allow_in, .if_to_id_data,
        .id_to_ex_valid, .ex_allow_in, .id_to_ex_data, .br,
        .rf(rf_bus.master), .ex_fwd, .mem_fwd, .wb_fwd
    );

    regfile rf_i (
        .clk, .rf(rf_bus.slave), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    ex_stage ex_i (
        .clk, .reset, .id_to_ex_valid, .ex_allow_in, .id_to_ex_data,
        .ex_to_mem_valid, .ex_to_mem_data, .store_data, .ex_fwd
    );

    mem_stage mem_i (
        .clk, .reset, .ex_to_mem_valid, .ex_to_mem_data, .store_data,
        .data_en, .data_we, .data_addr, .data_wdata, .data_rdata,
        .mem_to_wb_valid, .mem_to_wb_data, .mem_fwd
    );

    wb_stage wb_i (
        .clk, .reset, .mem_to_wb_valid, .mem_to_wb_data,
        .rf_we, .rf_waddr, .rf_wdata, .wb_fwd,
        .debug_wb_pc, .debug_wb_we, .debug_wb_rnum, .debug_wb_data
    );

endmodule

`default_nettype wire

/* cpu_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_props (
    input wire       clk,
    input wire       reset,
    input wire       id_valid,
    input wire       need_wait,
    input wire       br_taken,
    input wire       if_to_id_valid,
    input wire [4:0] ex_dest
);

    // fetch drops the instruction behind a taken branch in the same cycle
    branch_drops_fetch: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> !if_to_id_valid)
        else $error("fetch offered an instruction behind a taken branch");

    // the load-use bubble is a single cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (id_valid && need_wait) |=> !(id_valid && need_wait))
        else $error("decode stalled for more than one cycle");

    // the stalled instruction stays in decode, so execute holds a bubble next
    no_issue_in_stall: assert property (@(posedge clk) disable iff (reset)
        (id_valid && need_wait) |=> ex_dest == 5'd0)
        else $error("instruction passed to execute during a stall");

endmodule

bind id_stage cpu_core_props props_i (
    .clk, .reset, .id_valid, .need_wait, .br_taken, .if_to_id_valid,
    .ex_dest(ex_fwd.dest)
);

`default_nettype wire

/* cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rnum;
        logic [31:0] data;
    } wb_event_t;

    logic        clk;
    logic        reset;
    logic [31:0] inst_addr, inst_rdata, inst_off;
    logic        data_en, data_we;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [31:0] debug_wb_pc, debug_wb_data;
    logic        debug_wb_we;
    logic [4:0]  debug_wb_rnum;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    wb_event_t   exp_q [$];
    int          prog_len;
    int          limit;
    int          cycles;
    logic [15:0] lfsr;

    cpu_core dut_i (
        .clk, .reset, .inst_addr, .inst_rdata,
        .data_en, .data_we, .data_addr, .data_wdata, .data_rdata,
        .debug_wb_pc, .debug_wb_we, .debug_wb_rnum, .debug_wb_data
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign inst_off   = inst_addr - cpu_pkg::reset_pc;
    assign inst_rdata = imem[inst_off[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        logic [31:0] a;
        a = {24'b0, idx, 2'b0};
        return 32'ha500_0000 ^ (a * 32'h0001_0001);
    endfunction

    // data memory is refilled while reset is held
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) dmem[i] <= fill_word(i[5:0]);
        end else if (data_en && data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Test failed");
            $fatal(1, "simulation timed out after %0d cycles", cycles);
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] r3(input logic [16:0] op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12(input logic [9:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    // offsets count words, as in the encoding
    function automatic logic [31:0] br16(input logic [5:0] op, input logic [4:0] rj,
                                         input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic begin_program();
        @(negedge clk);
        reset = 1'b1;
        prog_len = 0;
        for (int i = 0; i < 64; i++) imem[i] = 32'h5000_0000;  // b to itself
    endtask

    task automatic emit(input logic [31:0] inst);
        imem[prog_len[5:0]] = inst;
        prog_len++;
    endtask

    // sequential model of the kept instructions, stops at a branch to itself
    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] m [64];
        logic [31:0] pc, inst, val, nxt, s12, o16, o26, addr, off;
        logic [4:0]  rd, rj, rk, dst;
        logic        wr;
        wb_event_t   ev;
        for (int i = 0; i < 64; i++) m[i] = fill_word(i[5:0]);
        for (int i = 0; i < 32; i++) r[i] = '0;
        exp_q.delete();
        pc = cpu_pkg::reset_pc;
        for (int step = 0; step < 200; step++) begin
            off  = pc - cpu_pkg::reset_pc;
            inst = imem[off[7:2]];
            rd   = inst[4:0];
            rj   = inst[9:5];
            rk   = inst[14:10];
            s12  = {{20{inst[21]}}, inst[21:10]};
            o16  = {{14{inst[25]}}, inst[25:10], 2'b0};
            o26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            nxt  = pc + 32'd4;
            wr   = 1'b1;
            dst  = rd;
            val  = '0;
            addr = r[rj] + s12;
            if (inst[31:26] == 6'h14 && o26 == 32'd0) break;
            if (inst[31:15] == 17'h20) val = r[rj] + r[rk];
            else if (inst[31:15] == 17'h22) val = r[rj] - r[rk];
            else if (inst[31:15] == 17'h24) val = {31'b0, $signed(r[rj]) < $signed(r[rk])};
            else if (inst[31:15] == 17'h25) val = {31'b0, r[rj] < r[rk]};
            else if (inst[31:15] == 17'h28) val = ~(r[rj] | r[rk]);
            else if (inst[31:15] == 17'h29) val = r[rj] & r[rk];
            else if (inst[31:15] == 17'h2a) val = r[rj] | r[rk];
            else if (inst[31:15] == 17'h2b) val = r[rj] ^ r[rk];
            else if (inst[31:22] == 10'h00a) val = addr;
            else if (inst[31:22] == 10'h0a2) val = m[addr[7:2]];
            else if (inst[31:22] == 10'h0a6) begin
                m[addr[7:2]] = r[rd];
                wr = 1'b0;
            end else if (inst[31:25] == 7'h0a) val = {inst[24:5], 12'b0};
            else if (inst[31:26] == 6'h13) begin
                val = pc + 32'd4;
                nxt = r[rj] + o16;
            end else if (inst[31:26] == 6'h14) begin
                wr  = 1'b0;
                nxt = pc + o26;
            end else if (inst[31:26] == 6'h15) begin
                val = pc + 32'd4;
                dst = 5'd1;
                nxt = pc + o26;
            end else if (inst[31:26] == 6'h16) begin
                wr = 1'b0;
                if (r[rj] == r[rd]) nxt = pc + o16;
            end else if (inst[31:26] == 6'h17) begin
                wr = 1'b0;
                if (r[rj] != r[rd]) nxt = pc + o16;
            end else wr = 1'b0;
            if (wr && dst != 5'd0) begin
                r[dst] = val;
                ev = '{pc: pc, rnum: dst, data: val};
                exp_q.push_back(ev);
            end
            pc = nxt;
        end
    endtask

    // the last reset cycle shows the idle outputs, then reset is released
    task automatic release_reset();
        repeat (8) @(negedge clk);
        assert (inst_addr == cpu_pkg::reset_pc && !data_en && !debug_wb_we)
        else begin
            $display("Error at %0t ns: in reset inst_addr %h data_en %b debug_wb_we %b",
                     $time, inst_addr, data_en, debug_wb_we);
            $display("Test failed");
            $fatal(1, "wrong outputs in reset");
        end
        reset = 1'b0;
    endtask

    task automatic start_run();
        run_model();
        limit = limit + prog_len * 4;
        release_reset();
    endtask

    // compares trace events first .. last-1 of the expected list, in order
    task automatic check_trace(input int first, input int last);
        int idx;
        wb_event_t e;
        idx = first;
        while (idx < last) begin
            @(negedge clk);
            if (!reset && debug_wb_we) begin
                e = exp_q[idx];
                assert (debug_wb_pc == e.pc && debug_wb_rnum == e.rnum
                        && debug_wb_data == e.data)
                else begin
                    $display("Error at %0t ns: write %0d pc %h r%0d = %h, expected pc %h r%0d = %h",
                             $time, idx, debug_wb_pc, debug_wb_rnum, debug_wb_data,
                             e.pc, e.rnum, e.data);
                    $display("Test failed");
                    $fatal(1, "trace mismatch");
                end
                idx++;
            end
        end
    endtask

    task automatic alu_program();
        logic [31:0] a, b, c;
        rand_bits(20, a);
        rand_bits(12, b);
        rand_bits(12, c);
        emit(lu12i(5'd4, a[19:0]));
        emit(ri12(10'h00a, 5'd4, 5'd4, b[11:0]));  // execute forward
        emit(ri12(10'h00a, 5'd5, 5'd0, c[11:0]));
        emit(r3(17'h20, 5'd6, 5'd4, 5'd5));        // memory and execute forwards
        emit(r3(17'h22, 5'd7, 5'd6, 5'd4));        // writeback forward for r4
        emit(r3(17'h24, 5'd8, 5'd7, 5'd6));
        emit(r3(17'h25, 5'd9, 5'd7, 5'd6));
        emit(r3(17'h29, 5'd10, 5'd6, 5'd7));
        emit(r3(17'h2a, 5'd11, 5'd10, 5'd5));
        emit(r3(17'h28, 5'd12, 5'd11, 5'd4));
        emit(r3(17'h2b, 5'd13, 5'd12, 5'd6));
    endtask

    task automatic alu_forward_test();
        begin_program();
        alu_program();
        start_run();
        check_trace(0, exp_q.size());
    endtask

    task automatic load_store_test();
        logic [31:0] v;
        begin_program();
        rand_bits(12, v);
        emit(ri12(10'h00a, 5'd4, 5'd0, 12'h040));
        emit(ri12(10'h0a2, 5'd5, 5'd4, 12'h008));
        emit(r3(17'h20, 5'd6, 5'd5, 5'd5));        // load-use stall
        emit(ri12(10'h00a, 5'd7, 5'd0, v[11:0]));
        emit(ri12(10'h0a6, 5'd7, 5'd4, 12'h00c));
        emit(ri12(10'h0a2, 5'd8, 5'd4, 12'h00c));
        emit(ri12(10'h00a, 5'd9, 5'd8, 12'h001));
        start_run();
        check_trace(0, exp_q.size());
    endtask

    task automatic branch_test();
        begin_program();
        emit(ri12(10'h00a, 5'd4, 5'd0, 12'h005));
        emit(ri12(10'h00a, 5'd5, 5'd0, 12'h005));
        emit(br16(6'h16, 5'd4, 5'd5, 16'd2));     // beq taken
        emit(ri12(10'h00a, 5'd6, 5'd0, 12'h001));
        emit(br16(6'h17, 5'd4, 5'd5, 16'd2));     // bne not taken
        emit(ri12(10'h00a, 5'd7, 5'd0, 12'h002));
        emit(br16(6'h16, 5'd4, 5'd7, 16'd2));     // beq not taken
        emit(br16(6'h17, 5'd4, 5'd7, 16'd2));     // bne taken
        emit(ri12(10'h00a, 5'd8, 5'd0, 12'h003));
        emit(br26(6'h14, 26'd2));
        emit(ri12(10'h00a, 5'd9, 5'd0, 12'h004));
        emit(ri12(10'h00a, 5'd10, 5'd0, 12'h006));
        start_run();
        check_trace(0, exp_q.size());
    endtask

    task automatic link_test();
        begin_program();
        emit(br26(6'h15, 26'd3));                  // bl to the subroutine
        emit(ri12(10'h00a, 5'd5, 5'd0, 12'h007));
        emit(br26(6'h14, 26'd3));
        emit(ri12(10'h00a, 5'd4, 5'd0, 12'h009));
        emit(br16(6'h13, 5'd1, 5'd2, 16'd0));     // jirl r2, r1, 0
        emit(ri12(10'h00a, 5'd6, 5'd5, 12'h001));
        start_run();
        check_trace(0, exp_q.size());
    endtask

    task automatic zero_reg_test();
        begin_program();
        emit(ri12(10'h00a, 5'd0, 5'd0, 12'h123));
        emit(r3(17'h20, 5'd4, 5'd0, 5'd0));
        emit(lu12i(5'd0, 20'h5a5a5));
        emit(ri12(10'h00a, 5'd5, 5'd0, 12'h003));
        start_run();
        check_trace(0, exp_q.size());
    endtask

    task automatic mid_reset_test();
        begin_program();
        alu_program();
        start_run();
        check_trace(0, 4);
        @(negedge clk);
        reset = 1'b1;
        release_reset();
        check_trace(0, exp_q.size());
    endtask

    initial begin
        reset    = 1'b1;
        lfsr     = 16'd43;
        limit    = 100;
        cycles   = 0;
        prog_len = 0;
        for (int i = 0; i < 64; i++) imem[i] = 32'h5000_0000;
        alu_forward_test();
        load_store_test();
        branch_test();
        link_test();
        zero_reg_test();
        mid_reset_test();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_core.f */
cpu_pkg.sv
rf_read_if.sv
if_stage.sv
id_stage.sv
regfile.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
cpu_core.sv
cpu_core_props.sv
cpu_core_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
verilator --binary --assert -j 0 --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim || exit 1
./obj_dir/cpu_core_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1 || grep -q "Test passed" sim.log || exit 1
exit 0
